/* aud_dsp.f */
+incdir+logic
logic/aud_dsp_pkg.sv
logic/play_ctrl.sv
logic/sample_addr_gen.sv
logic/sample_interp.sv
logic/aud_dsp_top.sv
tb/aud_dsp_tb.sv

/* logic/aud_dsp_params.svh */
`ifndef AUD_DSP_PARAMS_SVH
`define AUD_DSP_PARAMS_SVH

// default SRAM depth is 2^20 words
`define AUD_ADDR_W 20

// signed PCM sample width
`define AUD_SAMPLE_W 16

// speed code layout
// fast rates sit in the upper bits (code = step * 8)
// slow rates sit in the lower three bits (code = divisor - 1)
`define AUD_SPEED_W 8

// phase counter, enough for the divide by 8
`define AUD_PHASE_W 3

`endif

/* logic/aud_dsp_pkg.sv */
package aud_dsp_pkg;

`include "aud_dsp_params.svh"

    typedef logic signed [`AUD_SAMPLE_W-1:0] sample_t;

    // x1..x8 -> 8,16,..,64 ; x1/2 -> 1, x1/4 -> 3, x1/8 -> 7
    typedef logic [`AUD_SPEED_W-1:0] speed_code_t;

    typedef enum logic {
        INTERP_HOLD   = 1'b0, // sample and hold
        INTERP_LINEAR = 1'b1  // weighted average of prev and new
    } interp_mode_t;

    // playback settings from the top level
    typedef struct packed {
        speed_code_t  speed;
        interp_mode_t mode;
    } play_cfg_t;

    // per-tick info handed from the address generator to the interpolator
    typedef struct packed {
        logic                     tick;     // supported-rate sample tick
        logic                     slow;     // slow rate active
        logic [`AUD_PHASE_W-1:0]  phase;    // phase before update
        logic [1:0]               div_log2; // log2 of slow divisor
    } step_info_t;

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        PLAY  = 2'd1,
        PAUSE = 2'd2,
        STOP  = 2'd3
    } play_state_t;

endpackage

/* logic/aud_dsp_top.sv */
`timescale 1ns/10ps
`include "aud_dsp_params.svh"

module aud_dsp_top import aud_dsp_pkg::*; #(
    parameter int ADDR_W = `AUD_ADDR_W
) (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_start,
    input  logic              i_pause,
    input  logic              i_stop,
    input  speed_code_t       i_speed,
    input  interp_mode_t      i_interp,
    input  logic              i_daclrck,
    input  logic              i_player_ack,
    input  sample_t           i_sram_data,
    output sample_t           o_dac_data,
    output logic [ADDR_W-1:0] o_sram_addr,
    output logic              o_player_en
);

    play_cfg_t  cfg;
    step_info_t step;
    logic       tick;
    logic       clear;
    logic       mem_end;

    assign cfg.speed = i_speed;
    assign cfg.mode  = i_interp;

    play_ctrl u_play_ctrl (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_start      (i_start),
        .i_pause      (i_pause),
        .i_stop       (i_stop),
        .i_daclrck    (i_daclrck),
        .i_player_ack (i_player_ack),
        .i_end        (mem_end),
        .o_tick       (tick),
        .o_clear      (clear),
        .o_player_en  (o_player_en)
    );

    sample_addr_gen #(.ADDR_W(ADDR_W)) u_addr_gen (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_tick      (tick),
        .i_clear     (clear),
        .i_cfg       (cfg),
        .o_sram_addr (o_sram_addr),
        .o_step      (step),
        .o_end       (mem_end)
    );

    sample_interp u_interp (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_step      (step),
        .i_cfg       (cfg),
        .i_sram_data (i_sram_data),
        .o_dac_data  (o_dac_data)
    );

endmodule

/* logic/play_ctrl.sv */
`timescale 1ns/10ps

module play_ctrl import aud_dsp_pkg::*; (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_start,
    input  logic i_pause,
    input  logic i_stop,
    input  logic i_daclrck,
    input  logic i_player_ack,
    input  logic i_end,
    output logic o_tick,
    output logic o_clear,
    output logic o_player_en
);

    play_state_t state_r;
    play_state_t state_nxt;

    logic lrck_s1;
    logic lrck_s2;
    logic lrck_s3; // delayed copy of s2 for edge detect
    logic fall_r;
    logic player_en_r;

    // LRCK crosses in from the player clock domain
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            lrck_s1 <= 1'b0;
            lrck_s2 <= 1'b0;
            lrck_s3 <= 1'b0;
            fall_r  <= 1'b0;
        end else begin
            lrck_s1 <= i_daclrck;
            lrck_s2 <= lrck_s1;
            lrck_s3 <= lrck_s2;
            fall_r  <= lrck_s3 & ~lrck_s2; // high to low seen on s2
        end
    end

    always_comb begin
        state_nxt = state_r;
        case (state_r)
            IDLE: begin
                if (i_start) begin
                    state_nxt = PLAY;
                end
            end
            PLAY: begin
                if (i_stop) begin
                    state_nxt = STOP; // stop wins over pause
                end else if (i_end) begin
                    state_nxt = IDLE;
                end else if (i_pause) begin
                    state_nxt = PAUSE;
                end
            end
            PAUSE: begin
                if (i_start) begin
                    state_nxt = PLAY;
                end else if (i_stop) begin
                    state_nxt = STOP;
                end
            end
            default: begin
                state_nxt = IDLE; // STOP lasts a single cycle
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r     <= IDLE;
            player_en_r <= 1'b0;
        end else begin
            state_r <= state_nxt;
            if (state_r != PLAY) begin
                player_en_r <= 1'b0;
            end else if (o_tick) begin
                player_en_r <= 1'b1; // new sample ready next cycle
            end else if (i_player_ack) begin
                player_en_r <= 1'b0;
            end
        end
    end

    assign o_tick      = fall_r & (state_r == PLAY);
    assign o_clear     = (state_r == IDLE) || (state_r == STOP);
    assign o_player_en = player_en_r;

endmodule

/* logic/sample_addr_gen.sv */
`timescale 1ns/10ps
`include "aud_dsp_params.svh"

module sample_addr_gen import aud_dsp_pkg::*; #(
    parameter int ADDR_W = `AUD_ADDR_W
) (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_tick,
    input  logic              i_clear,
    input  play_cfg_t         i_cfg,
    output logic [ADDR_W-1:0] o_sram_addr,
    output step_info_t        o_step,
    output logic              o_end
);

    localparam int PH_W = `AUD_PHASE_W;

    logic [ADDR_W-1:0] addr_r;
    logic [PH_W-1:0]   phase_r;
    logic              is_fast;
    logic              is_slow;
    logic [3:0]        fast_step;
    logic [1:0]        div_log2;
    logic [PH_W-1:0]   last_phase;
    logic [3:0]        adv;
    logic [ADDR_W:0]   addr_sum;
    logic              overflow;

    // speed code decode
    always_comb begin
        is_fast   = 1'b0;
        is_slow   = 1'b0;
        fast_step = i_cfg.speed[6:3];
        div_log2  = 2'd0;
        case (i_cfg.speed)
            8'd1: begin
                is_slow  = 1'b1;
                div_log2 = 2'd1;
            end
            8'd3: begin
                is_slow  = 1'b1;
                div_log2 = 2'd2;
            end
            8'd7: begin
                is_slow  = 1'b1;
                div_log2 = 2'd3;
            end
            default: begin
                // step * 8, step 1..8
                is_fast = (i_cfg.speed[2:0] == 3'd0) && (i_cfg.speed[7:3] != 5'd0)
                          && (i_cfg.speed[7:3] <= 5'd8);
            end
        endcase
    end

    assign last_phase = i_cfg.speed[PH_W-1:0]; // divisor - 1 for slow codes

    always_comb begin
        adv = 4'd0;
        if (is_fast) begin
            adv = fast_step;
        end else if (is_slow) begin
            if (i_cfg.mode == INTERP_LINEAR) begin
                adv = (phase_r == '0) ? 4'd1 : 4'd0; // fetch the next word early
            end else begin
                adv = (phase_r == last_phase) ? 4'd1 : 4'd0;
            end
        end
    end

    assign addr_sum = (ADDR_W+1)'(addr_r) + (ADDR_W+1)'(adv);
    assign overflow = addr_sum[ADDR_W]; // step passes the last word

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            addr_r  <= '0;
            phase_r <= '0;
        end else if (i_clear) begin
            addr_r  <= '0;
            phase_r <= '0;
        end else if (i_tick) begin
            if (!overflow) begin
                addr_r <= addr_sum[ADDR_W-1:0];
            end
            if (is_slow) begin
                phase_r <= (phase_r == last_phase) ? '0 : phase_r + PH_W'(1);
            end
        end
    end

    assign o_sram_addr     = addr_r;
    assign o_end           = i_tick & overflow;
    assign o_step.tick     = i_tick & (is_fast | is_slow); // unsupported codes hold
    assign o_step.slow     = is_slow;
    assign o_step.phase    = phase_r;
    assign o_step.div_log2 = div_log2;

endmodule

/* logic/sample_interp.sv */
`timescale 1ns/10ps
`include "aud_dsp_params.svh"

module sample_interp import aud_dsp_pkg::*; (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  step_info_t i_step,
    input  play_cfg_t  i_cfg,
    input  sample_t    i_sram_data,
    output sample_t    o_dac_data
);

    localparam int PH_W  = `AUD_PHASE_W;
    localparam int ACC_W = `AUD_SAMPLE_W + PH_W + 3; // room for both products and the sum

    sample_t                  prev_r;
    sample_t                  dac_r;
    logic                     linear;
    logic [PH_W:0]            n_val;
    logic signed [PH_W+1:0]   wt_new;
    logic signed [PH_W+1:0]   wt_old;
    logic signed [ACC_W-1:0]  acc;
    logic signed [ACC_W-1:0]  acc_sh;

    assign linear = i_step.slow && (i_cfg.mode == INTERP_LINEAR);

    // weights k and N-k
    assign n_val  = (PH_W+1)'(1) << i_step.div_log2;
    assign wt_new = $signed({2'b00, i_step.phase});
    assign wt_old = $signed({1'b0, n_val}) - wt_new;

    always_comb begin
        acc    = ACC_W'(i_sram_data) * ACC_W'(wt_new) + ACC_W'(prev_r) * ACC_W'(wt_old);
        acc_sh = acc >>> i_step.div_log2; // floor toward -inf
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            dac_r <= '0;
        end else if (i_step.tick) begin
            if (linear && (i_step.phase != '0)) begin
                dac_r <= acc_sh[`AUD_SAMPLE_W-1:0];
            end else begin
                dac_r <= i_sram_data; // fast, hold, or linear phase 0
            end
        end
    end

    // anchor for the next interpolation run
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            prev_r <= '0;
        end else if (i_step.tick && linear && (i_step.phase == '0)) begin
            prev_r <= i_sram_data;
        end
    end

    assign o_dac_data = dac_r;

endmodule

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps --top-module aud_dsp_tb -f aud_dsp.f

out=$(./obj_dir/Vaud_dsp_tb)
echo "$out"

# a missing pass line fails the script
echo "$out" | grep -qx "sim passed"

/* tb/aud_dsp_tb.sv */
`timescale 1ns/10ps

module aud_dsp_tb import aud_dsp_pkg::*; ();

    // expected result of one tick plus the model state after it
    typedef struct packed {
        logic [7:0] addr;
        logic [2:0] phase;
        sample_t    prev;
        sample_t    data;
    } ref_res_t;

    logic         i_clk = 1'b0;
    logic         i_rst_n = 1'b0;
    logic         i_start = 1'b0;
    logic         i_pause = 1'b0;
    logic         i_stop = 1'b0;
    speed_code_t  i_speed = '0;
    interp_mode_t i_interp = INTERP_HOLD;
    logic         i_daclrck = 1'b0;
    logic         i_player_ack = 1'b0;
    sample_t      i_sram_data;
    sample_t      o_dac_data;
    logic [7:0]   o_sram_addr;
    logic         o_player_en;

    sample_t      mem [0:255];
    integer       seed = 86350;
    int           err_cnt = 0;
    int           timeout_cnt = 0;
    int           check_cnt = 0;
    int           sample_cnt = 0;
    int           run_cnt = 0; // bumped on every start from idle
    logic [7:0]   ref_addr = '0;
    logic [2:0]   ref_phase = '0;
    sample_t      ref_prev = '0;
    sample_t      ref_last = '0;

    aud_dsp_top #(.ADDR_W(8)) u_dut (.*);

    always #20 i_clk = ~i_clk;

    // player LRCK, one falling edge every 32 clocks
    always begin
        repeat (16) @(posedge i_clk);
        #2 i_daclrck = ~i_daclrck;
    end

    assign i_sram_data = mem[o_sram_addr]; // async SRAM read

    function automatic ref_res_t predict(input logic [7:0] addr, input logic [2:0] phase,
                                         input speed_code_t speed, input interp_mode_t mode,
                                         input sample_t prev, input sample_t last);
        ref_res_t r;
        int code;
        int k;
        int n;
        int lg;
        int adv;
        int wsum;
        code = int'(speed);
        k    = int'(phase);
        n    = code + 1;
        lg   = (n == 2) ? 1 : ((n == 4) ? 2 : 3);
        adv  = 0;
        r    = {addr, phase, prev, last}; // unsupported codes leave everything alone
        if ((code % 8 == 0) && (code >= 8) && (code <= 64)) begin
            adv    = code / 8;
            r.data = mem[addr];
        end else if ((code == 1) || (code == 3) || (code == 7)) begin
            r.phase = 3'((k + 1) % n);
            if (mode == INTERP_HOLD) begin
                r.data = mem[addr];
                adv    = (k == n - 1) ? 1 : 0;
            end else if (k == 0) begin
                r.data = mem[addr];
                r.prev = mem[addr];
                adv    = 1;
            end else begin
                wsum   = int'(mem[addr]) * k + int'(prev) * (n - k);
                r.data = sample_t'(wsum >>> lg); // rounds toward -inf
            end
        end
        if (int'(addr) + adv <= 255) begin
            r.addr = 8'(int'(addr) + adv); // held when the step passes the last word
        end
        return r;
    endfunction

    task automatic check_sample(input sample_t got, input sample_t want, input string what);
        check_cnt++;
        if (got !== want) begin
            err_cnt++;
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, want);
        end
    endtask

    task automatic check_addr(input logic [7:0] got, input logic [7:0] want, input string what);
        check_cnt++;
        if (got !== want) begin
            err_cnt++;
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, want);
        end
    endtask

    task automatic check_level(input logic got, input logic want, input string what);
        check_cnt++;
        if (got !== want) begin
            err_cnt++;
            $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, want);
        end
    endtask

    // compare on every rising player enable, then acknowledge
    initial begin
        ref_res_t res;
        logic     en_d;
        int       seen_run;
        en_d     = 1'b0;
        seen_run = 0;
        forever begin
            @(negedge i_clk);
            if (o_player_en && !en_d) begin
                if (seen_run != run_cnt) begin
                    ref_addr  = '0; // new run starts at word 0
                    ref_phase = '0;
                    seen_run  = run_cnt;
                end
                res = predict(ref_addr, ref_phase, i_speed, i_interp, ref_prev, ref_last);
                check_sample(o_dac_data, res.data, "dac sample");
                check_addr(o_sram_addr, res.addr, "sram address");
                {ref_addr, ref_phase, ref_prev, ref_last} = res;
                sample_cnt++;
                @(posedge i_clk);
                #2 i_player_ack = 1'b1;
                @(posedge i_clk);
                #2 i_player_ack = 1'b0;
            end
            en_d = o_player_en;
        end
    end

    task automatic drive_controls(input logic start, input logic pause, input logic stop);
        @(posedge i_clk);
        #2 {i_start, i_pause, i_stop} = {start, pause, stop};
        @(posedge i_clk);
        #2 {i_start, i_pause, i_stop} = 3'b000;
    endtask

    task automatic wait_samples(input int n, input string what);
        int goal;
        int waited;
        goal   = sample_cnt + n;
        waited = 0;
        while ((sample_cnt < goal) && (waited < n * 40 + 100)) begin
            @(posedge i_clk);
            waited++;
        end
        if (sample_cnt < goal) begin
            timeout_cnt++;
            $display("timeout in %s: the player enable did not pulse often enough", what);
        end
    endtask

    task automatic expect_quiet(input int periods, input string what);
        repeat (periods * 32) begin
            @(negedge i_clk);
            check_level(o_player_en, 1'b0, what);
        end
    endtask

    // speed and mode only change while idle
    task automatic start_run(input speed_code_t speed, input interp_mode_t mode);
        @(posedge i_clk);
        #2 i_speed = speed;
        i_interp = mode;
        run_cnt++;
        drive_controls(1'b1, 1'b0, 1'b0);
    endtask

    task automatic stop_run();
        drive_controls(1'b0, 1'b0, 1'b1);
        expect_quiet(1, "player enable after stop");
        check_addr(o_sram_addr, '0, "sram address after stop");
    endtask

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = sample_t'($random(seed));
        end
        repeat (3) @(posedge i_clk);
        #2 i_rst_n = 1'b1;
        @(negedge i_clk);
        check_level(o_player_en, 1'b0, "player enable after reset");
        check_sample(o_dac_data, '0, "dac sample after reset");
        check_addr(o_sram_addr, '0, "sram address after reset");

        // x1 with pause and resume, then stop and restart from word 0
        start_run(8'd8, INTERP_HOLD);
        wait_samples(6, "x1 run");
        drive_controls(1'b0, 1'b1, 1'b0);
        expect_quiet(4, "player enable during pause");
        drive_controls(1'b1, 1'b0, 1'b0);
        wait_samples(4, "x1 resume");
        stop_run();
        start_run(8'd8, INTERP_HOLD);
        wait_samples(3, "x1 restart");
        stop_run();

        // x4 and x8 run into the last word
        start_run(8'd32, INTERP_HOLD);
        wait_samples(64, "x4 run");
        expect_quiet(4, "player enable after end of memory");
        check_addr(o_sram_addr, '0, "sram address after end of memory");
        start_run(8'd64, INTERP_HOLD);
        wait_samples(32, "x8 run");
        expect_quiet(4, "player enable after end of memory");
        check_addr(o_sram_addr, '0, "sram address after end of memory");

        start_run(8'd3, INTERP_HOLD); // x1/4 hold
        wait_samples(12, "x1/4 hold run");
        stop_run();
        start_run(8'd1, INTERP_LINEAR);
        wait_samples(10, "x1/2 linear run");
        stop_run();
        start_run(8'd7, INTERP_LINEAR);
        wait_samples(24, "x1/8 linear run");
        stop_run();
        start_run(8'd2, INTERP_HOLD); // unsupported code
        wait_samples(4, "unsupported code run");
        stop_run();

        $display("checks %0d, samples %0d, errors %0d, timeouts %0d",
                 check_cnt, sample_cnt, err_cnt, timeout_cnt);
        if ((err_cnt == 0) && (timeout_cnt == 0)) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
